// File: filelist.f
logic/etx_pkg.sv
logic/emesh_packet_decode.sv
logic/wait_synchronizer.sv
logic/etx_protocol.sv
logic/etx_link_framer.sv
logic/etx_top.sv
sim/etx_tb.sv

// File: Bender.yml
package:
  name: etx

dependencies: {}

sources:
  # RTL, package first
  - logic/etx_pkg.sv
  - logic/emesh_packet_decode.sv
  - logic/wait_synchronizer.sv
  - logic/etx_protocol.sv
  - logic/etx_link_framer.sv
  - logic/etx_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/etx_tb.sv

export_include_dirs: []

vendor_package: []

# Simulation top is etx_tb, synthesis top is etx_top

// File: sim/etx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module etx_tb;

  import etx_pkg::*;

  localparam logic [ID_W-1:0] NODE_ID = 12'h123;
  localparam int SYNC_STAGES    = 2;
  localparam int NUM_ROWS       = 17;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 12 + 200;   // Rows times worst row length

  // One stimulus row with data and srcaddr left to the LCG
  typedef struct packed {
    logic       write;
    datamode_t  dm;
    logic [3:0] cm;
    logic [31:0] dst;
    logic       en;
    logic       b2b;                    // Offered with no idle cycle before it
    logic [7:0] link_wait;              // Link stall cycles after acceptance
    logic [7:0] wr_hold;                // Far-side write wait cycles
  } row_t;

  logic              clk;
  logic              reset;
  logic              etx_access;
  logic [PW-1:0]     etx_packet;
  logic              tx_enable;
  logic              tx_rd_wait;
  logic              tx_wr_wait;
  logic              link_wait;
  logic              etx_rd_wait;
  logic              etx_wr_wait;
  logic              link_valid;
  beat_kind_t        link_kind;
  logic [TAG_W-1:0]  link_tag;
  logic [DW-1:0]     link_data;

  row_t  rows [NUM_ROWS];
  string names [NUM_ROWS];

  // Expected beats in arrival order
  beat_kind_t        exp_kind_q [$];
  logic [TAG_W-1:0]  exp_tag_q  [$];
  logic [DW-1:0]     exp_data_q [$];
  string             exp_name_q [$];

  // Reference model memory of the last registered packet
  logic        prev_valid;
  logic        prev_write;
  datamode_t   prev_dm;
  logic [3:0]  prev_cm;
  logic [31:0] prev_dst;

  logic [31:0] lcg_state = 32'ha6ce;
  int          cycle_count = 0;
  int          beat_errors = 0;
  int          wait_errors = 0;
  int          other_errors = 0;

  etx_top #(
    .ID          (NODE_ID),
    .SYNC_STAGES (SYNC_STAGES)
  ) etx_top_inst (
    .clk         (clk),
    .reset       (reset),
    .etx_access  (etx_access),
    .etx_packet  (etx_packet),
    .tx_enable   (tx_enable),
    .tx_rd_wait  (tx_rd_wait),
    .tx_wr_wait  (tx_wr_wait),
    .link_wait   (link_wait),
    .etx_rd_wait (etx_rd_wait),
    .etx_wr_wait (etx_wr_wait),
    .link_valid  (link_valid),
    .link_kind   (link_kind),
    .link_tag    (link_tag),
    .link_data   (link_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;             // 20 ns period
  end

  //######################################################################
  // Helpers
  //######################################################################
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [PW-1:0] make_packet(input logic write, input datamode_t dm,
      input logic [3:0] cm, input logic [31:0] dst, input logic [31:0] data,
      input logic [31:0] src, input logic spare);
    return {src, data, dst, spare, cm, dm, write};  // Spare bit 7 must be ignored
  endfunction

  task automatic check_beat(input string name, input beat_kind_t exp_kind,
      input logic [TAG_W-1:0] exp_tag, input logic [DW-1:0] exp_data,
      input beat_kind_t act_kind, input logic [TAG_W-1:0] act_tag,
      input logic [DW-1:0] act_data);
    if (act_kind !== exp_kind || act_tag !== exp_tag || act_data !== exp_data)
    begin
      $display("** Error %s: beat expected kind %s tag %h data %h, actual kind %s tag %h data %h",
               name, exp_kind.name(), exp_tag, exp_data, act_kind.name(), act_tag, act_data);
      beat_errors++;
    end
  endtask

  task automatic check_wait(input string name, input logic exp_rd, input logic exp_wr,
      input logic act_rd, input logic act_wr);
    if (act_rd !== exp_rd || act_wr !== exp_wr)
    begin
      $display("** Error %s: pushback expected rd %b wr %b, actual rd %b wr %b",
               name, exp_rd, exp_wr, act_rd, act_wr);
      wait_errors++;
    end
  endtask

  task automatic push_beat(input string name, input beat_kind_t kind,
      input logic [TAG_W-1:0] tag, input logic [DW-1:0] data);
    exp_name_q.push_back(name);
    exp_kind_q.push_back(kind);
    exp_tag_q.push_back(tag);
    exp_data_q.push_back(data);
  endtask

  task automatic set_row(input int i, input string n, input logic w, input datamode_t dm,
      input logic [3:0] cm, input logic [31:0] dst, input logic en, input logic b2b,
      input int lw, input int wh);
    names[i] = n;
    rows[i]  = '{w, dm, cm, dst, en, b2b, 8'(lw), 8'(wh)};
  endtask

  //######################################################################
  // Stimulus table
  //######################################################################
  task automatic build_table();
    set_row(0,  "word_write",         1, DM_WORD,   4'h3, 32'h0820_0100, 1, 0, 0, 0);
    set_row(1,  "read",               0, DM_WORD,   4'h0, 32'h0820_0200, 1, 0, 0, 0);
    set_row(2,  "read_disabled",      0, DM_WORD,   4'h0, 32'h0820_0204, 0, 0, 0, 0);
    set_row(3,  "burst_start",        1, DM_DOUBLE, 4'h5, 32'h0840_1000, 1, 0, 0, 0);
    set_row(4,  "burst_cont1",        1, DM_DOUBLE, 4'h5, 32'h0840_1008, 1, 1, 0, 0);
    set_row(5,  "burst_cont2",        1, DM_DOUBLE, 4'h5, 32'h0840_1010, 1, 1, 0, 0);
    set_row(6,  "burst_gap",          1, DM_DOUBLE, 4'h5, 32'h0840_1018, 1, 0, 0, 0);
    set_row(7,  "burst_mode_change",  1, DM_DOUBLE, 4'h6, 32'h0840_1020, 1, 1, 0, 0);
    set_row(8,  "burst_bad_stride",   1, DM_DOUBLE, 4'h6, 32'h0840_1030, 1, 1, 0, 0);
    set_row(9,  "burst_after_stride", 1, DM_DOUBLE, 4'h6, 32'h0840_1038, 1, 1, 0, 0);
    set_row(10, "own_node_dropped",   1, DM_WORD,   4'h1, 32'h1230_0040, 1, 0, 0, 0);
    set_row(11, "own_node_regs",      1, DM_WORD,   4'h1, 32'h123E_0040, 1, 0, 0, 0);
    set_row(12, "read_during_wr_wait", 0, DM_WORD,  4'h2, 32'h0820_0300, 1, 0, 0, 4);
    set_row(13, "write_held",         1, DM_WORD,   4'h2, 32'h0820_0400, 1, 0, 0, 5);
    set_row(14, "link_stall_double",  1, DM_DOUBLE, 4'h2, 32'h0820_0500, 1, 0, 4, 0);
    set_row(15, "link_stall_cont",    1, DM_DOUBLE, 4'h2, 32'h0820_0508, 1, 1, 3, 0);
    set_row(16, "read_b2b",           0, DM_HALF,   4'h7, 32'h0820_0600, 1, 1, 0, 0);
  endtask

  //######################################################################
  // Reference model and row driving
  //######################################################################
  task automatic predict(input int i, input logic [DW-1:0] data, input logic [AW-1:0] src);
    row_t r;
    logic valid;
    logic burst;
    r = rows[i];
    // Own node outside the register group is swallowed
    valid = r.en && !((r.dst[31:20] == NODE_ID) && (r.dst[19:16] != EGROUP_RR));
    burst = valid && r.write && (r.dm == DM_DOUBLE) && r.b2b && prev_valid &&
            ({r.write, r.dm, r.cm} == {prev_write, prev_dm, prev_cm}) &&
            (r.dst == prev_dst + 32'd8);
    if (valid && !burst)
      push_beat(names[i], BEAT_HEAD, {1'b0, r.cm, r.dm, r.write}, r.dst);
    if (valid)
      push_beat(names[i], BEAT_DATA, '0, r.write ? data : src);
    prev_valid = valid;
    prev_write = r.write;
    prev_dm    = r.dm;
    prev_cm    = r.cm;
    prev_dst   = r.dst;
  endtask

  // Wait for owed beats and idle long enough to clear register and sync chain
  task automatic drain();
    int         n;
    beat_kind_t missing_kind;
    etx_access = 1'b0;
    n = 0;
    while (exp_kind_q.size() != 0 && n < 60)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    while (exp_kind_q.size() != 0)
    begin
      missing_kind = exp_kind_q.pop_front();
      $display("Missing beat: %s never sent its %s beat",
               exp_name_q.pop_front(), missing_kind.name());
      void'(exp_tag_q.pop_front());
      void'(exp_data_q.pop_front());
      other_errors++;
    end
    repeat (SYNC_STAGES + 1)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic raise_wr_wait(input string name);
    tx_wr_wait = 1'b1;
    for (int e = 1; e <= SYNC_STAGES; e++)
    begin
      @(posedge clk);
      @(negedge clk);
      check_wait(name, 1'b0, logic'(e == SYNC_STAGES), etx_rd_wait, etx_wr_wait);
    end
    @(posedge clk);
    #2;
  endtask

  // Hold the packet until an edge sees its pushback low
  task automatic offer(input string name, input logic [PW-1:0] pkt, input logic write,
      input int wr_hold, output int waited);
    logic blocked;
    waited = 0;
    etx_packet = pkt;
    etx_access = 1'b1;
    forever
    begin
      if (wr_hold != 0 && waited == wr_hold)
        tx_wr_wait = 1'b0;              // Far side releases
      @(negedge clk);
      if (waited < wr_hold)
        check_wait(name, 1'b0, 1'b1, etx_rd_wait, etx_wr_wait);
      blocked = write ? etx_wr_wait : etx_rd_wait;
      @(posedge clk);
      #2;
      waited++;
      if (!blocked)
        break;
    end
    etx_access = 1'b0;
  endtask

  task automatic stall_link(input string name, input int cycles);
    for (int k = 0; k < cycles; k++)
    begin
      link_wait = 1'b1;
      @(negedge clk);
      check_wait(name, 1'b1, 1'b1, etx_rd_wait, etx_wr_wait);  // Both held
      @(posedge clk);
      #2;
    end
    link_wait = 1'b0;
  endtask

  task automatic run_row(input int i);
    logic [DW-1:0] data;
    logic [AW-1:0] src;
    int            waited;
    if (!rows[i].b2b)
      drain();
    data = next_random();
    src  = next_random();
    tx_enable = rows[i].en;
    predict(i, data, src);
    if (rows[i].wr_hold != 0)
      raise_wr_wait(names[i]);
    offer(names[i], make_packet(rows[i].write, rows[i].dm, rows[i].cm, rows[i].dst,
          data, src, src[31]), rows[i].write, rows[i].wr_hold, waited);
    if (rows[i].wr_hold != 0)
    begin
      tx_wr_wait = 1'b0;
      if (rows[i].write && waited <= rows[i].wr_hold)
      begin
        $display("%s: write went out while the far side still asked to wait", names[i]);
        other_errors++;
      end
    end
    stall_link(names[i], rows[i].link_wait);
  endtask

  //######################################################################
  // Beat monitor and watchdog
  //######################################################################
  always @(negedge clk)
  begin
    if (!reset && link_valid === 1'b1)
    begin
      if (exp_kind_q.size() == 0)
      begin
        $display("Unexpected beat on the link: kind %s tag %h data %h",
                 link_kind.name(), link_tag, link_data);
        other_errors++;
      end
      else
        check_beat(exp_name_q.pop_front(), exp_kind_q.pop_front(), exp_tag_q.pop_front(),
                   exp_data_q.pop_front(), link_kind, link_tag, link_data);
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: beat %0d, wait %0d, other %0d", beat_errors, wait_errors,
               other_errors);
      $display("Some tests failed");
      $finish;
    end
  end

  //######################################################################
  // Main sequence
  //######################################################################
  initial
  begin
    reset      = 1'b1;
    etx_access = 1'b0;
    etx_packet = '0;
    tx_enable  = 1'b0;
    tx_rd_wait = 1'b0;
    tx_wr_wait = 1'b0;
    link_wait  = 1'b0;
    prev_valid = 1'b0;
    prev_write = 1'b0;
    prev_dm    = DM_BYTE;
    prev_cm    = '0;
    prev_dst   = '0;
    build_table();
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    drain();                            // Last row's beats
    $display("Errors: beat %0d, wait %0d, other %0d", beat_errors, wait_errors, other_errors);
    if (beat_errors + wait_errors + other_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/etx_top.sv
`timescale 1ns/1ps
`default_nettype none

// Transmit stage top: sync, protocol, framer
module etx_top #(
  parameter logic [etx_pkg::ID_W-1:0] ID = '0,
  parameter int SYNC_STAGES = 2
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         etx_access,
  input  wire [etx_pkg::PW-1:0]       etx_packet,
  input  wire                         tx_enable,
  input  wire                         tx_rd_wait,   // Async from far side
  input  wire                         tx_wr_wait,
  input  wire                         link_wait,
  output logic                        etx_rd_wait,
  output logic                        etx_wr_wait,
  output logic                        link_valid,
  output etx_pkg::beat_kind_t         link_kind,
  output logic [etx_pkg::TAG_W-1:0]   link_tag,
  output logic [etx_pkg::DW-1:0]      link_data
);

  import etx_pkg::*;

  logic           rd_wait_sync;
  logic           wr_wait_sync;
  logic           tx_access;
  logic [PW-1:0]  tx_packet;
  logic           tx_burst;
  logic           tx_io_wait;     // Framer back to protocol

  wait_synchronizer #(
    .SYNC_STAGES (SYNC_STAGES)
  ) wait_sync (
    .clk           (clk),
    .reset         (reset),
    .rd_wait_async (tx_rd_wait),
    .wr_wait_async (tx_wr_wait),
    .rd_wait       (rd_wait_sync),
    .wr_wait       (wr_wait_sync)
  );

  etx_protocol #(
    .ID (ID)
  ) protocol (
    .clk         (clk),
    .reset       (reset),
    .etx_access  (etx_access),
    .etx_packet  (etx_packet),
    .tx_enable   (tx_enable),
    .rd_wait     (rd_wait_sync),
    .wr_wait     (wr_wait_sync),
    .tx_io_wait  (tx_io_wait),
    .etx_rd_wait (etx_rd_wait),
    .etx_wr_wait (etx_wr_wait),
    .tx_access   (tx_access),
    .tx_packet   (tx_packet),
    .tx_burst    (tx_burst)
  );

  etx_link_framer framer (
    .clk        (clk),
    .reset      (reset),
    .tx_access  (tx_access),
    .tx_packet  (tx_packet),
    .tx_burst   (tx_burst),
    .link_wait  (link_wait),
    .tx_io_wait (tx_io_wait),
    .link_valid (link_valid),
    .link_kind  (link_kind),
    .link_tag   (link_tag),
    .link_data  (link_data)
  );

endmodule

`default_nettype wire

// File: logic/etx_link_framer.sv
`timescale 1ns/1ps
`default_nettype none

// Link framer turning one registered packet into header and data beats
module etx_link_framer (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         tx_access,
  input  wire [etx_pkg::PW-1:0]       tx_packet,
  input  wire                         tx_burst,
  input  wire                         link_wait,    // Link not ready
  output logic                        tx_io_wait,
  output logic                        link_valid,
  output etx_pkg::beat_kind_t         link_kind,
  output logic [etx_pkg::TAG_W-1:0]   link_tag,
  output logic [etx_pkg::DW-1:0]      link_data
);

  import etx_pkg::*;

  framer_state_t    state;
  framer_state_t    state_next;

  logic             pkt_write;
  datamode_t        pkt_datamode;
  logic [CM_W-1:0]  pkt_ctrlmode;
  logic [AW-1:0]    pkt_dstaddr;
  logic [DW-1:0]    pkt_data;
  logic [AW-1:0]    pkt_srcaddr;

  logic             beat_out;     // A beat leaves this cycle
  logic             head_beat;    // ... and it is a header

  emesh_packet_decode pkt_decode (
    .packet   (tx_packet),
    .write    (pkt_write),
    .datamode (pkt_datamode),
    .ctrlmode (pkt_ctrlmode),
    .dstaddr  (pkt_dstaddr),
    .data     (pkt_data),
    .srcaddr  (pkt_srcaddr)
  );

  //####################################################################
  // Beat sequencing FSM
  //####################################################################
  always_comb
  begin
    state_next = state;
    beat_out   = 1'b0;
    head_beat  = 1'b0;
    case (state)
      FR_IDLE:
      begin
        if (tx_access && !link_wait)
        begin
          beat_out  = 1'b1;
          head_beat = !tx_burst;        // Continuation skips the header
          if (!tx_burst)
            state_next = FR_DATA_PENDING;
        end
      end
      FR_DATA_PENDING:
      begin
        if (!link_wait)
        begin
          beat_out   = 1'b1;            // Data beat of the same packet
          state_next = FR_IDLE;
        end
      end
      default: state_next = FR_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= FR_IDLE;
    else
      state <= state_next;
  end

  // Hold the packet register through the header cycle and any link stall
  // The data beat cycle lets the next packet load behind it
  assign tx_io_wait = link_wait | head_beat;

  //####################################################################
  // Beat contents
  //####################################################################
  assign link_valid = beat_out;
  assign link_kind  = (state == FR_IDLE && !tx_burst) ? BEAT_HEAD : BEAT_DATA;

  always_comb
  begin
    if (link_kind == BEAT_HEAD)
    begin
      link_tag  = {1'b0, pkt_ctrlmode, pkt_datamode, pkt_write};  // Packet control byte
      link_data = pkt_dstaddr;
    end
    else
    begin
      link_tag  = '0;
      link_data = pkt_write ? pkt_data : pkt_srcaddr;  // Reads send return address
    end
  end

  // Link stall wins over everything
  a_no_beat_in_wait: assert property (@(posedge clk) disable iff (reset)
    link_wait |-> !link_valid);

  // Burst flag from the protocol stage suppresses the header
  a_no_burst_header: assert property (@(posedge clk) disable iff (reset)
    (link_valid && link_kind == BEAT_HEAD) |-> !tx_burst);

endmodule

`default_nettype wire

// File: logic/etx_protocol.sv
`timescale 1ns/1ps
`default_nettype none

// Transmit protocol stage that filters, registers and burst-flags packets
module etx_protocol #(
  parameter logic [etx_pkg::ID_W-1:0] ID = '0     // This node's mesh coordinate
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     etx_access,
  input  wire [etx_pkg::PW-1:0]   etx_packet,
  input  wire                     tx_enable,
  input  wire                     rd_wait,        // Synchronized far-side waits
  input  wire                     wr_wait,
  input  wire                     tx_io_wait,     // Framer busy
  output logic                    etx_rd_wait,
  output logic                    etx_wr_wait,
  output logic                    tx_access,
  output logic [etx_pkg::PW-1:0]  tx_packet,
  output logic                    tx_burst
);

  import etx_pkg::*;

  // Incoming packet
  logic             etx_write;
  datamode_t        etx_datamode;
  logic [CM_W-1:0]  etx_ctrlmode;
  logic [AW-1:0]    etx_dstaddr;

  // Registered packet
  logic             last_write;
  datamode_t        last_datamode;
  logic [CM_W-1:0]  last_ctrlmode;
  logic [AW-1:0]    last_dstaddr;

  logic             own_node;
  logic             in_reg_group;
  logic             dir_clear;
  logic             etx_valid;
  logic             burst_type_match;
  logic             burst_addr_match;
  logic             burst_next;

  emesh_packet_decode in_decode (
    .packet   (etx_packet),
    .write    (etx_write),
    .datamode (etx_datamode),
    .ctrlmode (etx_ctrlmode),
    .dstaddr  (etx_dstaddr),
    .data     (),
    .srcaddr  ()
  );

  emesh_packet_decode last_decode (
    .packet   (tx_packet),
    .write    (last_write),
    .datamode (last_datamode),
    .ctrlmode (last_ctrlmode),
    .dstaddr  (last_dstaddr),
    .data     (),
    .srcaddr  ()
  );

  //####################################################################
  // Acceptance filter
  //####################################################################
  assign own_node     = (etx_dstaddr[ID_LSB +: ID_W] == ID);
  assign in_reg_group = (etx_dstaddr[GROUP_LSB +: GROUP_W] == EGROUP_RR);
  assign dir_clear    = etx_write ? ~wr_wait : ~rd_wait;    // Wait of its own direction

  // Own node outside register space is dropped here
  assign etx_valid = etx_access &
                     tx_enable &
                     dir_clear &
                     ~(own_node & ~in_reg_group);

  //####################################################################
  // Burst detection against the registered packet
  //####################################################################
  assign burst_type_match = ({etx_ctrlmode, etx_datamode, etx_write} ==
                             {last_ctrlmode, last_datamode, last_write});
  assign burst_addr_match = (etx_dstaddr == last_dstaddr + AW'(8));   // Next double word

  assign burst_next = etx_valid &
                      etx_write &
                      (etx_datamode == DM_DOUBLE) &
                      tx_access &                   // Previous one still live
                      burst_type_match &
                      burst_addr_match;

  //####################################################################
  // Packet register frozen while the framer is busy
  //####################################################################
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_access <= 1'b0;
      tx_burst  <= 1'b0;
    end
    else if (!tx_io_wait)
    begin
      tx_access <= etx_valid;
      tx_burst  <= burst_next;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!tx_io_wait)
      tx_packet <= etx_packet;        // Meaningful only with tx_access
  end

  // Pushback toward the system
  assign etx_rd_wait = rd_wait | tx_io_wait;
  assign etx_wr_wait = wr_wait | tx_io_wait;

  // Burst flag never appears without the packet it belongs to
  a_burst_has_access: assert property (@(posedge clk) disable iff (reset)
    tx_burst |-> tx_access);

endmodule

`default_nettype wire

// File: logic/wait_synchronizer.sv
`timescale 1ns/1ps
`default_nettype none

// Flop chain for the far-side wait levels
module wait_synchronizer #(
  parameter int SYNC_STAGES = 2
) (
  input  wire  clk,
  input  wire  reset,
  input  wire  rd_wait_async,
  input  wire  wr_wait_async,
  output logic rd_wait,
  output logic wr_wait
);

  logic [1:0] sync_q [SYNC_STAGES];     // {rd, wr} per stage

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < SYNC_STAGES; i++)
        sync_q[i] <= 2'b00;             // No wait after reset
    end
    else
    begin
      sync_q[0] <= {rd_wait_async, wr_wait_async};  // First stage samples async
      for (int i = 1; i < SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
    end
  end

  // Last stage is the settled level
  assign rd_wait = sync_q[SYNC_STAGES-1][1];
  assign wr_wait = sync_q[SYNC_STAGES-1][0];

endmodule

`default_nettype wire

// File: logic/emesh_packet_decode.sv
`timescale 1ns/1ps
`default_nettype none

// Field splitter for the 104-bit mesh packet
module emesh_packet_decode (
  input  wire [etx_pkg::PW-1:0]     packet,
  output logic                      write,
  output etx_pkg::datamode_t        datamode,
  output logic [etx_pkg::CM_W-1:0]  ctrlmode,
  output logic [etx_pkg::AW-1:0]    dstaddr,
  output logic [etx_pkg::DW-1:0]    data,
  output logic [etx_pkg::AW-1:0]    srcaddr
);

  import etx_pkg::*;

  //####################################################################
  // Control byte
  //####################################################################
  assign write    = packet[WRITE_BIT];                            // 1 = write
  assign datamode = datamode_t'(packet[DM_LSB +: $bits(datamode_t)]);
  assign ctrlmode = packet[CM_LSB +: CM_W];

  // Bit 7 is spare and ignored

  //####################################################################
  // Address and payload words
  //####################################################################
  assign dstaddr = packet[DST_LSB +: AW];     // Target, carries node ID
  assign data    = packet[DATA_LSB +: DW];    // Write data
  assign srcaddr = packet[SRC_LSB +: AW];     // Return address for reads

endmodule

`default_nettype wire

// File: logic/etx_pkg.sv
`default_nettype none

package etx_pkg;

  //####################################################################
  // Widths
  //####################################################################
  localparam int PW    = 104;           // Mesh packet
  localparam int AW    = 32;            // Address
  localparam int DW    = 32;            // Data
  localparam int TAG_W = 8;             // Link tag of a header beat

  //####################################################################
  // Packet layout, lsb of each field
  //####################################################################
  localparam int WRITE_BIT = 0;
  localparam int DM_LSB    = 1;         // Datamode, 2 bits
  localparam int CM_LSB    = 3;         // Ctrlmode
  localparam int CM_W      = 4;
  localparam int DST_LSB   = 8;         // Bit 7 left unused
  localparam int DATA_LSB  = 40;
  localparam int SRC_LSB   = 72;

  // Node coordinate and group code inside dstaddr
  localparam int ID_W      = 12;
  localparam int ID_LSB    = 20;        // dstaddr[31:20]
  localparam int GROUP_W   = 4;
  localparam int GROUP_LSB = 16;        // dstaddr[19:16]

  localparam logic [GROUP_W-1:0] EGROUP_RR = 4'hE;  // Register region of a node

  //####################################################################
  // Types
  //####################################################################
  typedef enum logic [1:0] {
    DM_BYTE   = 2'b00,
    DM_HALF   = 2'b01,
    DM_WORD   = 2'b10,
    DM_DOUBLE = 2'b11                   // Only size that may burst
  } datamode_t;

  typedef enum logic {
    BEAT_HEAD = 1'b0,                   // Control and address
    BEAT_DATA = 1'b1                    // Data or return address
  } beat_kind_t;

  typedef enum logic {
    FR_IDLE         = 1'b0,
    FR_DATA_PENDING = 1'b1              // Header out, data beat owed
  } framer_state_t;

endpackage

`default_nettype wire
